//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GMII receive testbench with Verilator.
# The exit status is nonzero when the build fails or the testbench stops on $fatal.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gmii_rx -f sources.f \
    -Mdir obj_dir -o tb_gmii_rx \
    && ./obj_dir/tb_gmii_rx \
    || { echo "Simulation did not pass"; exit 1; }

//--- sources.f
+incdir+verification
verilog/gmii_rx_pkg.sv
verilog/rx_byte_if.sv
verilog/crc32_byte.sv
verilog/rx_preamble_framer.sv
verilog/rx_frame_checker.sv
verilog/sync_fifo.sv
verilog/gmii_rx_top.sv
verification/tb_gmii_rx.sv

//--- verification/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// ------------------------------------------------------------
// Reference model for one received frame
// ------------------------------------------------------------

// Reflected CRC-32 of IEEE 802.3, bit 0 of each byte goes first
function automatic logic [31:0] fcs_of(input logic [7:0] data[$]);
    logic [31:0] crc;

    crc = 32'hFFFF_FFFF;                      // Preset to all ones
    foreach (data[i]) begin
        crc = crc ^ {24'h0, data[i]};
        for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
        end
    end
    return ~crc;                              // FCS is the complement
endfunction

// Fills frame_body with payload and FCS.
// Queues the words and the status that the DUT owes for it.
// room is the number of words the word FIFO can still take.
task automatic build_frame(input int n_payload, input bit bad_fcs, input bit pre_bad,
                           input bit er_set, input int room);
    logic [31:0] fcs;
    logic [31:0] stat;
    logic [15:0] w;
    int          n_words;

    frame_body.delete();
    for (int i = 0; i < n_payload; i++) begin
        frame_body.push_back(8'($urandom));   // Random payload
    end
    fcs = fcs_of(frame_body);
    if (bad_fcs)
        fcs = fcs ^ (32'h1 << ($urandom % 32));   // One bit flipped
    for (int i = 0; i < 4; i++) begin
        frame_body.push_back(fcs[8*i +: 8]);  // Low FCS byte first on the wire
    end

    // Byte pairs, first byte high, odd tail padded with zero
    n_words = (frame_body.size() + 1) / 2;
    for (int i = 0; i < n_words; i++) begin
        w[15:8] = frame_body[2*i];
        w[7:0]  = (2*i + 1 < frame_body.size()) ? frame_body[2*i+1] : 8'h00;
        if (i < room)
            exp_words.push_back(w);           // Words past room are dropped
    end

    stat = 32'(frame_body.size());            // Count includes the FCS
    stat[gmii_rx_pkg::STAT_CRC_OK_BIT]  = ~bad_fcs;
    stat[gmii_rx_pkg::STAT_PRE_ERR_BIT] = pre_bad;
    stat[gmii_rx_pkg::STAT_RX_ERR_BIT]  = er_set;
    stat[gmii_rx_pkg::STAT_OVF_BIT]     = (n_words > room);
    exp_stats.push_back(stat);
endtask

`endif

//--- verification/tb_gmii_rx.sv
`default_nettype none

module tb_gmii_rx;

    // ------------------------------------------------------------
    // Test sizes and timing
    // ------------------------------------------------------------
    localparam int CLK_PERIOD   = 100;
    localparam int DRV_DLY      = 10;     // Inputs change this long after the edge
    localparam int WORD_DEPTH   = 64;     // Small word FIFO, overflow comes cheap
    localparam int STAT_DEPTH   = 16;
    localparam int N_GOOD       = 24;     // Random good frames
    localparam int MAX_PAYLOAD  = 90;
    localparam int OVF_PAYLOAD  = 200;    // Well past WORD_DEPTH words
    localparam int IFG          = 12;     // Idle cycles between frames
    localparam int PRE_LEN      = 7;
    localparam int FRAME_CYCLES = PRE_LEN + 1 + MAX_PAYLOAD + 4 + IFG + 4;
    localparam int TEST_CYCLES  = (N_GOOD + 5) * FRAME_CYCLES + OVF_PAYLOAD + 40;
    localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES + 2000;
    localparam logic [7:0] PRE_BYTE = 8'h55;
    localparam logic [7:0] SFD      = 8'hD5;

    logic        RxClk;
    logic        rst_n;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        rx_er;
    logic [15:0] word_data;
    logic        word_valid;
    logic        word_ready;
    logic [31:0] stat_data;
    logic        stat_valid;
    logic        stat_ready;
    logic        hold_words;       // Keeps word_ready low

    logic [7:0]  frame_body[$];    // Payload and FCS of the frame in flight
    logic [15:0] exp_words[$];     // Words still owed by the DUT
    logic [31:0] exp_stats[$];     // Statuses still owed

    `include "tb_frame_model.svh"

    gmii_rx_top #(
        .WORD_FIFO_DEPTH (WORD_DEPTH),
        .STAT_FIFO_DEPTH (STAT_DEPTH)
    ) uut (
        .RxClk      (RxClk),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_er      (rx_er),
        .word_data  (word_data),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .stat_data  (stat_data),
        .stat_valid (stat_valid),
        .stat_ready (stat_ready)
    );

    initial RxClk = 1'b0;
    always #(CLK_PERIOD / 2) RxClk = ~RxClk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else report_failure($sformatf("Error at %0t: %s expected %h, got %h",
                                      $time, name, exp, act));
    endtask

    // ------------------------------------------------------------
    // Output checks
    // ------------------------------------------------------------
    always @(posedge RxClk) begin
        if (rst_n && word_valid && word_ready) begin   // Word transfer
            if (exp_words.size() == 0)
                report_failure("The word stream delivered a word that no frame produced");
            else
                check_value("word_data", 32'(exp_words.pop_front()), 32'(word_data));
        end
        if (rst_n && stat_valid && stat_ready) begin   // Status transfer
            if (exp_stats.size() == 0)
                report_failure("The status stream delivered a status that no frame produced");
            else
                check_value("stat_data", exp_stats.pop_front(), stat_data);
        end
    end

    a_word_hold: assert property (@(posedge RxClk) disable iff (!rst_n)
        (word_valid && !word_ready) |=> (word_valid && $stable(word_data)))
        else report_failure("word_valid fell or word_data moved before the transfer");
    a_stat_hold: assert property (@(posedge RxClk) disable iff (!rst_n)
        (stat_valid && !stat_ready) |=> (stat_valid && $stable(stat_data)))
        else report_failure("stat_valid fell or stat_data moved before the transfer");
    a_reset_empty: assert property (@(posedge RxClk)
        !rst_n |=> (!word_valid && !stat_valid))
        else report_failure("An output stream was valid during reset");

    // Random ready on both streams, word side can be held off
    always begin
        @(posedge RxClk);
        #DRV_DLY;
        word_ready = hold_words ? 1'b0 : ($urandom % 4 != 0);
        stat_ready = ($urandom % 4 != 0);
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic drive_byte(input logic [7:0] b, input logic er);
        @(posedge RxClk);
        #DRV_DLY;
        rx_valid = 1'b1;
        rx_data  = b;
        rx_er    = er;
    endtask

    task automatic send_frame(input int n_payload, input int n_pre, input logic [7:0] sfd,
                              input bit bad_fcs, input int er_idx);
        bit pre_bad;

        pre_bad = (n_pre != PRE_LEN) || (sfd != SFD);
        build_frame(n_payload, bad_fcs, pre_bad, er_idx >= 0, WORD_DEPTH);
        for (int i = 0; i < n_pre; i++) begin
            drive_byte(PRE_BYTE, 1'b0);
        end
        drive_byte(sfd, 1'b0);
        foreach (frame_body[i]) begin
            drive_byte(frame_body[i], i == er_idx);
        end
        @(posedge RxClk);
        #DRV_DLY;
        rx_valid = 1'b0;      // First idle cycle after the frame
        rx_er    = 1'b0;
        rx_data  = 8'h00;
        if (exp_stats.size() == 1) begin   // Status FIFO empty, latency is exact
            repeat (2) @(posedge RxClk);
            #1;
            check_value("stat_valid", 32'd0, 32'(stat_valid));
            @(posedge RxClk);
            #1;
            check_value("stat_valid", 32'd1, 32'(stat_valid));
        end
        repeat (IFG) @(posedge RxClk);
    endtask

    task automatic wait_drained();
        do begin
            @(posedge RxClk);
            #1;    // Queues settled after this edge's transfers
        end while (exp_words.size() != 0 || exp_stats.size() != 0);
    endtask

    initial begin
        int len;

        void'($urandom(32'h58dd));
        rst_n      = 1'b0;
        rx_valid   = 1'b0;
        rx_data    = 8'h00;
        rx_er      = 1'b0;
        word_ready = 1'b0;
        stat_ready = 1'b0;
        hold_words = 1'b0;
        repeat (16) @(posedge RxClk);
        #DRV_DLY;
        rst_n = 1'b1;
        repeat (4) @(posedge RxClk);

        for (int f = 0; f < N_GOOD; f++) begin   // Good frames
            send_frame(1 + int'($urandom % MAX_PAYLOAD), PRE_LEN, SFD, 1'b0, -1);
        end
        send_frame(1 + int'($urandom % MAX_PAYLOAD), PRE_LEN, SFD, 1'b1, -1);   // Bad FCS
        send_frame(1 + int'($urandom % MAX_PAYLOAD), 6, SFD, 1'b0, -1);   // Short preamble
        send_frame(1 + int'($urandom % MAX_PAYLOAD), PRE_LEN, 8'hD4, 1'b0, -1);   // Wrong SFD
        len = 1 + int'($urandom % MAX_PAYLOAD);
        send_frame(len, PRE_LEN, SFD, 1'b0, int'($urandom % len));   // RX_ER on one byte
        wait_drained();

        // Word FIFO held full, the tail of this frame is lost
        hold_words = 1'b1;
        @(posedge RxClk);
        send_frame(OVF_PAYLOAD, PRE_LEN, SFD, 1'b0, -1);
        repeat (20) @(posedge RxClk);
        hold_words = 1'b0;
        wait_drained();

        repeat (8) @(posedge RxClk);
        #1;
        check_value("word_valid", 32'd0, 32'(word_valid));   // Nothing left over
        check_value("stat_valid", 32'd0, 32'(stat_valid));
        $display("Result: PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("Timeout, the test did not finish within the watchdog time");
    end

endmodule

`default_nettype wire

//--- verilog/crc32_byte.sv
`default_nettype none

// One byte step of the Ethernet CRC-32, purely combinational.
// The register runs MSB first, while the wire sends each byte LSB first,
// so the byte is mirrored before it is shifted in.
module crc32_byte (
    input  gmii_rx_pkg::crc_t  crc_in,    // Running CRC
    input  gmii_rx_pkg::byte_t data,      // Byte as received
    output gmii_rx_pkg::crc_t  crc_out    // CRC with the byte folded in
);

    localparam gmii_rx_pkg::crc_t POLY = 32'h04C1_1DB7;   // IEEE 802.3

    gmii_rx_pkg::byte_t data_rev;

    // ------------------------------------------------------------
    // Bit reversal
    // ------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            data_rev[i] = data[7 - i];   // data[0] ends up in bit 7
        end
    end

    // ------------------------------------------------------------
    // Eight serial LFSR steps, unrolled
    // ------------------------------------------------------------
    always_comb begin : crc_steps
        gmii_rx_pkg::crc_t c;
        logic              fb;

        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = c[31] ^ data_rev[i];    // Oldest bit meets new data bit
            c  = {c[30:0], 1'b0};
            if (fb)
                c = c ^ POLY;
        end
        crc_out = c;
    end

endmodule

`default_nettype wire

//--- verilog/gmii_rx_pkg.sv
`default_nettype none

package gmii_rx_pkg;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------
    typedef logic [7:0]  byte_t;       // One GMII byte
    typedef logic [15:0] word_t;       // Two bytes, first one in [15:8]
    typedef logic [31:0] crc_t;        // CRC-32 register
    typedef logic [11:0] nbytes_t;     // Frame length incl FCS
    typedef logic [31:0] rx_status_t;  // One status word per frame

    // Status word layout, byte count sits in the low bits
    localparam int STAT_CRC_OK_BIT  = 16;  // FCS matched
    localparam int STAT_PRE_ERR_BIT = 17;  // Preamble or SFD wrong
    localparam int STAT_RX_ERR_BIT  = 18;  // PHY flagged RX_ER
    localparam int STAT_OVF_BIT     = 19;  // Words dropped, FIFO full

    // ------------------------------------------------------------
    // Framing constants
    // ------------------------------------------------------------
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;      // 0x55 bytes ahead of SFD

    // CRC start value and the remainder of a good frame plus its FCS.
    // The register is kept MSB first, with data fed LSB first as on the wire.
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

    // ------------------------------------------------------------
    // Framer FSM
    // ------------------------------------------------------------
    typedef enum logic [1:0] {
        FR_IDLE,      // Waiting for RX_DV
        FR_PREAMBLE,  // Counting 0x55 bytes
        FR_PAYLOAD    // Past the SFD, passing bytes on
    } framer_state_t;

endpackage

`default_nettype wire

//--- verilog/gmii_rx_top.sv
`default_nettype none

module gmii_rx_top #(
    parameter int WORD_FIFO_DEPTH = 1024,   // 16-bit words
    parameter int STAT_FIFO_DEPTH = 16      // Frames
) (
    input  logic                    RxClk,
    input  logic                    rst_n,
    // GMII receive
    input  logic                    rx_valid,
    input  gmii_rx_pkg::byte_t      rx_data,
    input  logic                    rx_er,
    // Word stream
    output gmii_rx_pkg::word_t      word_data,
    output logic                    word_valid,
    input  logic                    word_ready,
    // Status stream
    output gmii_rx_pkg::rx_status_t stat_data,
    output logic                    stat_valid,
    input  logic                    stat_ready
);

    logic                    word_wr_en;
    gmii_rx_pkg::word_t      word_din;
    logic                    word_full;
    logic                    word_empty;
    logic                    stat_wr_en;
    gmii_rx_pkg::rx_status_t stat_din;
    logic                    stat_full;
    logic                    stat_empty;

    rx_byte_if bytes_if ();

    // ------------------------------------------------------------
    // Receive datapath
    // ------------------------------------------------------------
    rx_preamble_framer u_framer (
        .RxClk, .rst_n, .rx_valid, .rx_data, .rx_er,
        .bytes (bytes_if.framer)
    );

    rx_frame_checker u_checker (
        .RxClk, .rst_n,
        .bytes (bytes_if.chk),
        .word_wr_en, .word_din, .word_full,
        .stat_wr_en, .stat_din, .stat_full
    );

    // ------------------------------------------------------------
    // Output FIFOs, valid/ready on the read side
    // ------------------------------------------------------------
    assign word_valid = ~word_empty;
    assign stat_valid = ~stat_empty;

    sync_fifo #(.WIDTH($bits(gmii_rx_pkg::word_t)), .DEPTH(WORD_FIFO_DEPTH)) u_word_fifo (
        .RxClk, .rst_n,
        .wr_en (word_wr_en), .din (word_din),
        .rd_en (word_valid & word_ready),      // Pop on transfer
        .dout  (word_data), .full (word_full), .empty (word_empty)
    );

    sync_fifo #(.WIDTH($bits(gmii_rx_pkg::rx_status_t)), .DEPTH(STAT_FIFO_DEPTH)) u_stat_fifo (
        .RxClk, .rst_n,
        .wr_en (stat_wr_en), .din (stat_din),
        .rd_en (stat_valid & stat_ready),
        .dout  (stat_data), .full (stat_full), .empty (stat_empty)
    );

endmodule

`default_nettype wire

//--- verilog/rx_byte_if.sv
`default_nettype none

// Byte stream from the framer to the frame checker.
// No ready signal, the PHY cannot be stalled.
interface rx_byte_if;

    gmii_rx_pkg::byte_t data;   // Payload byte
    logic strobe;               // data is a payload byte this cycle
    logic first;                // Byte 0 of the frame
    logic frame_end;            // Pulse after the last byte
    logic pre_err;              // Bad preamble, valid with frame_end
    logic rx_err;               // RX_ER seen, valid with frame_end

    // Source side
    modport framer (
        output data, strobe, first, frame_end, pre_err, rx_err
    );

    // Sink side
    modport chk (
        input data, strobe, first, frame_end, pre_err, rx_err
    );

endinterface

`default_nettype wire

//--- verilog/rx_frame_checker.sv
`default_nettype none

module rx_frame_checker (
    input  logic                    RxClk,
    input  logic                    rst_n,
    rx_byte_if.chk                  bytes,        // From the framer
    output logic                    word_wr_en,   // Word FIFO write
    output gmii_rx_pkg::word_t      word_din,
    input  logic                    word_full,
    output logic                    stat_wr_en,   // Status FIFO write
    output gmii_rx_pkg::rx_status_t stat_din,
    input  logic                    stat_full
);

    gmii_rx_pkg::crc_t    crc_q;       // Running CRC over the frame
    gmii_rx_pkg::crc_t    crc_base;    // CRC the current byte builds on
    gmii_rx_pkg::crc_t    crc_next;
    gmii_rx_pkg::nbytes_t nbytes_q;    // Bytes so far, FCS included
    gmii_rx_pkg::byte_t   hi_q;        // Even byte waiting for its pair
    logic                 odd_pos;     // Strobed byte completes a word
    logic                 word_want;   // A word is due this cycle
    logic                 ovf_q;       // Word lost in this frame
    logic                 pre_err_q;
    logic                 rx_err_q;
    logic                 crc_ok;

    // ------------------------------------------------------------
    // CRC
    // ------------------------------------------------------------
    assign crc_base = bytes.first ? gmii_rx_pkg::CRC_INIT : crc_q;   // Restart on byte 0

    crc32_byte u_crc (
        .crc_in  (crc_base),
        .data    (bytes.data),
        .crc_out (crc_next)
    );

    assign crc_ok = (crc_q == gmii_rx_pkg::CRC_RESIDUE);

    // Pair completes on an odd byte, or at the end for an odd-length tail
    assign odd_pos   = ~bytes.first & nbytes_q[0];
    assign word_want = (bytes.strobe & odd_pos) | (bytes.frame_end & nbytes_q[0]);

    // ------------------------------------------------------------
    // Write strobes
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            word_wr_en <= 1'b0;
            stat_wr_en <= 1'b0;
        end else begin
            word_wr_en <= word_want & ~word_full;        // Full FIFO drops the word
            stat_wr_en <= bytes.frame_end & ~stat_full;  // Status one cycle after end
        end
    end

    // Per-frame datapath
    always_ff @(posedge RxClk) begin
        if (bytes.strobe) begin
            crc_q    <= crc_next;
            nbytes_q <= bytes.first ? gmii_rx_pkg::nbytes_t'(1) : nbytes_q + 1'b1;
            if (!odd_pos)
                hi_q <= bytes.data;   // Upper half of next word
        end
        if (word_want)
            word_din <= bytes.frame_end ? {hi_q, 8'h00} : {hi_q, bytes.data};
        if (bytes.strobe && bytes.first)
            ovf_q <= 1'b0;
        else if (word_want && word_full)
            ovf_q <= 1'b1;
        if (bytes.frame_end) begin
            pre_err_q <= bytes.pre_err;   // Framer may move on next cycle
            rx_err_q  <= bytes.rx_err;
        end
    end

    // ------------------------------------------------------------
    // Status word
    // ------------------------------------------------------------
    always_comb begin
        stat_din = '0;
        stat_din[$bits(gmii_rx_pkg::nbytes_t)-1:0] = nbytes_q;
        stat_din[gmii_rx_pkg::STAT_CRC_OK_BIT]      = crc_ok;
        stat_din[gmii_rx_pkg::STAT_PRE_ERR_BIT]     = pre_err_q;
        stat_din[gmii_rx_pkg::STAT_RX_ERR_BIT]      = rx_err_q;
        stat_din[gmii_rx_pkg::STAT_OVF_BIT]         = ovf_q;
    end

    // Framer ends only frames that carried bytes
    a_stat_nonzero: assert property (@(posedge RxClk) disable iff (!rst_n)
        stat_wr_en |-> (stat_din[$bits(gmii_rx_pkg::nbytes_t)-1:0] != '0));

endmodule

`default_nettype wire

//--- verilog/rx_preamble_framer.sv
`default_nettype none

module rx_preamble_framer (
    input  logic               RxClk,
    input  logic               rst_n,
    input  logic               rx_valid,   // GMII RX_DV
    input  gmii_rx_pkg::byte_t rx_data,    // GMII RXD
    input  logic               rx_er,      // GMII RX_ER
    rx_byte_if.framer          bytes       // Payload bytes out
);

    gmii_rx_pkg::framer_state_t state;
    logic [3:0] pre_cnt;       // 0x55 bytes so far, saturating
    logic [3:0] pre_cnt_cur;   // Count that applies to this byte
    logic       first_pend;    // No payload byte strobed yet
    logic       is_pre;
    logic       is_sfd;

    // A frame may start straight from idle, so the count restarts there
    assign pre_cnt_cur = (state == gmii_rx_pkg::FR_IDLE) ? 4'd0 : pre_cnt;
    assign is_pre      = (rx_data == gmii_rx_pkg::PREAMBLE_BYTE);
    assign is_sfd      = (rx_data == gmii_rx_pkg::SFD_BYTE);

    // ------------------------------------------------------------
    // Framing FSM
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            state           <= gmii_rx_pkg::FR_IDLE;
            pre_cnt         <= 4'd0;
            first_pend      <= 1'b0;
            bytes.strobe    <= 1'b0;
            bytes.first     <= 1'b0;
            bytes.frame_end <= 1'b0;
            bytes.pre_err   <= 1'b0;
            bytes.rx_err    <= 1'b0;
        end else begin
            bytes.strobe    <= 1'b0;   // Single-cycle by default
            bytes.frame_end <= 1'b0;
            case (state)
                gmii_rx_pkg::FR_IDLE,
                gmii_rx_pkg::FR_PREAMBLE: begin
                    if (rx_valid) begin
                        // Error flag restarts with each new frame
                        if (state == gmii_rx_pkg::FR_IDLE)
                            bytes.rx_err <= rx_er;
                        else
                            bytes.rx_err <= bytes.rx_err | rx_er;
                        if (is_pre) begin
                            pre_cnt <= (pre_cnt_cur == 4'hF) ? pre_cnt_cur
                                                             : pre_cnt_cur + 4'd1;
                            state   <= gmii_rx_pkg::FR_PREAMBLE;
                        end else begin
                            // End of preamble, right or wrong
                            bytes.pre_err <= !is_sfd ||
                                (pre_cnt_cur != 4'(gmii_rx_pkg::PREAMBLE_LEN));
                            first_pend    <= 1'b1;
                            state         <= gmii_rx_pkg::FR_PAYLOAD;
                        end
                    end else if (state == gmii_rx_pkg::FR_PREAMBLE) begin
                        state <= gmii_rx_pkg::FR_IDLE;   // Died in preamble, no frame
                    end
                end
                gmii_rx_pkg::FR_PAYLOAD: begin
                    if (rx_valid) begin
                        bytes.strobe <= 1'b1;
                        bytes.first  <= first_pend;
                        first_pend   <= 1'b0;
                        bytes.rx_err <= bytes.rx_err | rx_er;   // Sticky
                    end else begin
                        // Only frames that carried bytes get an end marker
                        bytes.frame_end <= ~first_pend;
                        first_pend      <= 1'b0;
                        state           <= gmii_rx_pkg::FR_IDLE;
                    end
                end
                default: state <= gmii_rx_pkg::FR_IDLE;
            endcase
        end
    end

    // Byte register, one cycle behind RXD
    always_ff @(posedge RxClk) begin
        if (rx_valid)
            bytes.data <= rx_data;
    end

    // Bytes only flow once the SFD has gone by
    a_strobe_in_payload: assert property (@(posedge RxClk) disable iff (!rst_n)
        bytes.strobe |-> (state == gmii_rx_pkg::FR_PAYLOAD));

endmodule

`default_nettype wire

//--- verilog/sync_fifo.sv
`default_nettype none

// Single-clock FIFO, head visible on dout while not empty
module sync_fifo #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 16
) (
    input  logic             RxClk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,   // Pops the head
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // Pointer width
    localparam int CW = $clog2(DEPTH + 1);                 // Count width

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;     // Entries held

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + AW'(1);
    endfunction

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];   // Show-ahead

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    always_ff @(posedge RxClk) begin
        if (wr_en)
            mem[wr_ptr] <= din;
    end

    // Pointers and count
    always_ff @(posedge RxClk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Producer and consumer both sit outside this module
    a_no_wr_full: assert property (@(posedge RxClk) disable iff (!rst_n)
        wr_en |-> !full);
    a_no_rd_empty: assert property (@(posedge RxClk) disable iff (!rst_n)
        rd_en |-> !empty);

endmodule

`default_nettype wire
